// ==== vlog.f ====
+incdir+test
src/decompose_pkg.sv
src/decompose_mod_2gamma2.sv
src/decompose_center.sv
src/coef_counter.sv
src/decompose_ctrl.sv
src/decompose_top.sv
test/decompose_tb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module decompose_tb -o decompose_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decompose_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi

// ==== test/decompose_tb_tasks.svh ====
// --------------------------------------------------
// Reference model and compare tasks
// --------------------------------------------------

// Decompose rule with r0 returned in mod-q form
task automatic ref_decompose(input coef_t r, output high_t r1, output coef_t r0);
    int rv;
    int lo;
    int hi;
    rv = int'(r);
    lo = rv % (2 * GAMMA2);
    if (lo > GAMMA2) begin
        lo = lo - 2 * GAMMA2;
    end
    // At q-1 the high part wraps and r0 steps down by one
    if (rv - lo == DILITHIUM_Q - 1) begin
        hi = 0;
        lo = lo - 1;
    end else begin
        hi = (rv - lo) / (2 * GAMMA2);
    end
    if (lo < 0) begin
        lo = lo + DILITHIUM_Q;
    end
    r1 = high_t'(hi);
    r0 = coef_t'(lo);
endtask

task automatic check_r1(input string name, input high_t got, input high_t exp);
    if (got !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic check_r0(input string name, input coef_t got, input coef_t exp);
    if (got !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                          input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        err_cnt++;
    end
endtask

// --------------------------------------------------
// Drive and block helpers
// --------------------------------------------------

task automatic pulse_start();
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
endtask

// One extra falling edge after done lets the monitor take the last write
task automatic wait_done();
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!done_o && n < TIMEOUT);
    if (!done_o) begin
        $display("done_o did not arrive within %0d cycles", TIMEOUT);
        err_cnt++;
    end
    @(negedge clk);
endtask

task automatic fill_random();
    int rnd;
    for (int k = 0; k < NUM_COEFFS; k++) begin
        rnd = $random(seed);
        coef_mem[k] = coef_t'((rnd & 32'h7fffffff) % DILITHIUM_Q);
    end
endtask

task automatic check_block();
    high_t exp_r1;
    coef_t exp_r0;
    if (wr_addr_q.size() != NUM_COEFFS) begin
        $display("%0d result writes seen instead of %0d", wr_addr_q.size(), NUM_COEFFS);
        err_cnt++;
    end
    for (int k = 0; k < NUM_COEFFS; k++) begin
        ref_decompose(coef_mem[k], exp_r1, exp_r0);
        check_r1($sformatf("r1_o[%0d]", k), res_r1[k], exp_r1);
        check_r0($sformatf("r0_o[%0d]", k), res_r0[k], exp_r0);
    end
endtask

task automatic run_block();
    pulse_start();
    wait_done();
    check_block();
endtask

task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
        $display("%s: ok", name);
    end else begin
        fail_cnt++;
        $display("%s: %0d errors", name, err_cnt - errs_before);
    end
endtask

// --------------------------------------------------
// Tests
// --------------------------------------------------

task automatic test_reset_and_busy_start();
    int errs;
    errs = err_cnt;
    @(negedge clk);
    check_flag("mem_rd_en_o", mem_rd_en_o, 1'b0);
    check_flag("mem_wr_en_o", mem_wr_en_o, 1'b0);
    check_flag("done_o", done_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    fill_random();
    pulse_start();
    // A second start in the middle of READ must be ignored
    repeat (3) @(posedge clk);
    pulse_start();
    wait_done();
    check_block();
    if (done_count != 1 || done_cycle != start_cycle + NUM_COEFFS + 3) begin
        $display("start while busy moved done_o to cycle %0d", done_cycle - start_cycle);
        err_cnt++;
    end
    report_test("reset and start while busy", errs);
endtask

task automatic test_corner_values();
    int errs;
    int corner [9];
    errs = err_cnt;
    corner = '{0, 1, GAMMA2, GAMMA2 + 1, 2 * GAMMA2, 3 * GAMMA2,
               DILITHIUM_Q - GAMMA2 - 1, DILITHIUM_Q - GAMMA2, DILITHIUM_Q - 1};
    // Small values pad the block past the corner list
    for (int k = 0; k < NUM_COEFFS; k++) begin
        coef_mem[k] = (k < 9) ? coef_t'(corner[k]) : coef_t'(3 * k + 2);
    end
    run_block();
    report_test("corner values", errs);
endtask

task automatic test_random_block();
    int errs;
    errs = err_cnt;
    fill_random();
    run_block();
    report_test("random block", errs);
endtask

task automatic test_timing();
    int errs;
    errs = err_cnt;
    for (int k = 0; k < NUM_COEFFS; k++) begin
        coef_mem[k] = coef_t'((k * 524287 + 12345) % DILITHIUM_Q);
    end
    run_block();
    // Write k lands four cycles after the start plus its index
    for (int k = 0; k < wr_addr_q.size(); k++) begin
        check_addr($sformatf("mem_wr_addr_o write %0d", k), wr_addr_q[k], ADDR_W'(k));
        if (wr_cycle_q[k] != start_cycle + 4 + k) begin
            $display("write %0d came %0d cycles after start instead of %0d",
                     k, wr_cycle_q[k] - start_cycle, 4 + k);
            err_cnt++;
        end
    end
    if (done_count != 1 || done_cycle != start_cycle + NUM_COEFFS + 3 || !done_with_wr) begin
        $display("done_o did not pulse once together with the last write");
        err_cnt++;
    end
    check_flag("busy_o", busy_o, 1'b0);
    report_test("timing and ordering", errs);
endtask

task automatic test_zeroize();
    int errs;
    int n;
    int wr_mark;
    errs = err_cnt;
    fill_random();
    pulse_start();
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!(mem_rd_en_o && mem_rd_addr_o == ADDR_W'(5)) && n < TIMEOUT);
    if (!(mem_rd_en_o && mem_rd_addr_o == ADDR_W'(5))) begin
        $display("read of index 5 never appeared before zeroize");
        err_cnt++;
    end
    @(posedge clk);
    zeroize_i <= 1'b1;
    @(posedge clk);
    zeroize_i <= 1'b0;
    @(negedge clk);
    wr_mark = wr_addr_q.size();
    // Observation window long enough for a whole block to drain
    repeat (NUM_COEFFS + 8) @(negedge clk);
    if (wr_addr_q.size() != wr_mark || done_count != 0) begin
        $display("writes or done_o appeared after zeroize");
        err_cnt++;
    end
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("mem_rd_en_o", mem_rd_en_o, 1'b0);
    fill_random();
    run_block();
    report_test("zeroize mid-block", errs);
endtask

// ==== test/decompose_tb.sv ====
`timescale 1ns/1ps

module decompose_tb;
    import decompose_pkg::*;

    localparam int DILITHIUM_Q = 8380417;
    localparam int GAMMA2      = (DILITHIUM_Q - 1) / 32;
    localparam int NUM_COEFFS  = 16;
    localparam int ADDR_W      = $clog2(NUM_COEFFS);
    // Longest wait for any single event, in cycles
    localparam int TIMEOUT     = 200;

    logic              clk;
    logic              reset_n;
    logic              zeroize_i;
    logic              start_i;
    logic              mem_rd_en_o;
    logic [ADDR_W-1:0] mem_rd_addr_o;
    coef_t             mem_rd_data_i = '0;
    logic              mem_wr_en_o;
    logic [ADDR_W-1:0] mem_wr_addr_o;
    high_t             r1_o;
    coef_t             r0_o;
    logic              busy_o;
    logic              done_o;

    // Coefficient memory, captured results and their arrival cycles
    coef_t             coef_mem [NUM_COEFFS];
    high_t             res_r1 [NUM_COEFFS];
    coef_t             res_r0 [NUM_COEFFS];
    logic [ADDR_W-1:0] wr_addr_q [$];
    int                wr_cycle_q [$];
    int                cycle = 0;
    int                start_cycle;
    int                done_cycle;
    int                done_count;
    logic              done_with_wr;
    int                err_cnt;
    int                test_cnt;
    int                fail_cnt;
    integer            seed;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Memory answers one cycle after the read strobe
    always @(posedge clk) begin
        if (mem_rd_en_o) begin
            mem_rd_data_i <= coef_mem[mem_rd_addr_o];
        end
    end

    // --------------------------------------------------
    // Result monitor, sampled on the falling edge
    // --------------------------------------------------

    always @(negedge clk) begin
        // An accepted start opens a fresh capture window
        if (reset_n && start_i && !busy_o) begin
            start_cycle = cycle;
            done_count  = 0;
            wr_addr_q.delete();
            wr_cycle_q.delete();
            for (int k = 0; k < NUM_COEFFS; k++) begin
                res_r1[k] = '0;
                res_r0[k] = '0;
            end
        end
        if (mem_wr_en_o) begin
            res_r1[mem_wr_addr_o] = r1_o;
            res_r0[mem_wr_addr_o] = r0_o;
            wr_addr_q.push_back(mem_wr_addr_o);
            wr_cycle_q.push_back(cycle);
        end
        if (done_o) begin
            done_count   = done_count + 1;
            done_cycle   = cycle;
            done_with_wr = mem_wr_en_o;
        end
    end

    decompose_top #(
        .DILITHIUM_Q (DILITHIUM_Q),
        .GAMMA2      (GAMMA2),
        .NUM_COEFFS  (NUM_COEFFS)
    ) decompose_top_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .start_i       (start_i),
        .mem_rd_en_o   (mem_rd_en_o),
        .mem_rd_addr_o (mem_rd_addr_o),
        .mem_rd_data_i (mem_rd_data_i),
        .mem_wr_en_o   (mem_wr_en_o),
        .mem_wr_addr_o (mem_wr_addr_o),
        .r1_o          (r1_o),
        .r0_o          (r0_o),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    `include "decompose_tb_tasks.svh"

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        clk          = 1'b0;
        reset_n      <= 1'b0;
        zeroize_i    <= 1'b0;
        start_i      <= 1'b0;
        err_cnt      = 0;
        test_cnt     = 0;
        fail_cnt     = 0;
        done_count   = 0;
        done_with_wr = 1'b0;
        seed         = 51;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_and_busy_start();
        test_corner_values();
        test_random_block();
        test_timing();
        test_zeroize();

        $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src/decompose_top.sv ====
`timescale 1ns/1ps

module decompose_top #(
    parameter int  DILITHIUM_Q = 8380417,
    parameter int  GAMMA2      = (DILITHIUM_Q - 1) / 32,
    parameter int  NUM_COEFFS  = 256,
    localparam int ADDR_W      = (NUM_COEFFS > 1) ? $clog2(NUM_COEFFS) : 1
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  logic                 start_i,
    output logic                 mem_rd_en_o,
    output logic [ADDR_W-1:0]    mem_rd_addr_o,
    input  decompose_pkg::coef_t mem_rd_data_i,
    output logic                 mem_wr_en_o,
    output logic [ADDR_W-1:0]    mem_wr_addr_o,
    output decompose_pkg::high_t r1_o,
    output decompose_pkg::coef_t r0_o,
    output logic                 busy_o,
    output logic                 done_o
);
    import decompose_pkg::*;

    logic cnt_clear;
    logic rd_last;
    logic wr_last;
    logic coef_valid;
    logic rem_valid;
    rem_t rem;

    // --------------------------------------------------
    // Control and addressing
    // --------------------------------------------------

    decompose_ctrl ctrl_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .start_i     (start_i),
        .rd_last_i   (rd_last),
        .wr_last_i   (wr_last),
        .wr_valid_i  (mem_wr_en_o),
        .rd_en_o     (mem_rd_en_o),
        .cnt_clear_o (cnt_clear),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    // Read addresses step with every issued read
    coef_counter #(.NUM_COEFFS(NUM_COEFFS)) rd_cnt_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .clear_i   (cnt_clear),
        .advance_i (mem_rd_en_o),
        .count_o   (mem_rd_addr_o),
        .last_o    (rd_last)
    );

    // Write addresses step with every result leaving the center stage
    coef_counter #(.NUM_COEFFS(NUM_COEFFS)) wr_cnt_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .clear_i   (cnt_clear),
        .advance_i (mem_wr_en_o),
        .count_o   (mem_wr_addr_o),
        .last_o    (wr_last)
    );

    // Memory answers one cycle after the read strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            coef_valid <= 1'b0;
        end else if (zeroize_i) begin
            coef_valid <= 1'b0;
        end else begin
            coef_valid <= mem_rd_en_o;
        end
    end

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------

    decompose_mod_2gamma2 #(.DILITHIUM_Q(DILITHIUM_Q), .GAMMA2(GAMMA2)) mod_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (coef_valid),
        .opa_i     (mem_rd_data_i),
        .res_o     (rem),
        .ready_o   (rem_valid)
    );

    decompose_center #(.DILITHIUM_Q(DILITHIUM_Q), .GAMMA2(GAMMA2)) center_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .coef_valid_i (coef_valid),
        .coef_i       (mem_rd_data_i),
        .rem_valid_i  (rem_valid),
        .rem_i        (rem),
        .r1_o         (r1_o),
        .r0_o         (r0_o),
        .valid_o      (mem_wr_en_o)
    );

endmodule

// ==== src/decompose_ctrl.sv ====
`timescale 1ns/1ps

module decompose_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  logic start_i,
    input  logic rd_last_i,
    input  logic wr_last_i,
    input  logic wr_valid_i,
    output logic rd_en_o,
    output logic cnt_clear_o,
    output logic busy_o,
    output logic done_o
);
    import decompose_pkg::*;

    // Cycles between the final read and the cycle that carries the last write
    // The pipeline is read, reduce, center, so two cycles remain after READ
    localparam int FLUSH_CYCLES = 2;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic [1:0]  flush_cnt_q;
    logic        flush_end;

    assign flush_end = (flush_cnt_q == 2'(FLUSH_CYCLES - 1));

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = READ;
                end
            end
            READ: begin
                // One read per cycle until the read counter shows its final index
                if (rd_last_i) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: begin
                if (flush_end) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else if (zeroize_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Counts the drain cycles and rests at zero outside FLUSH
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            flush_cnt_q <= '0;
        end else if (zeroize_i || (state_q != FLUSH)) begin
            flush_cnt_q <= '0;
        end else begin
            flush_cnt_q <= flush_cnt_q + 1'b1;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------

    assign rd_en_o     = (state_q == READ);
    // Both counters restart from index zero on an accepted start
    assign cnt_clear_o = (state_q == IDLE) && start_i;
    assign busy_o      = (state_q != IDLE);
    assign done_o      = (state_q == DONE) && wr_valid_i && wr_last_i;

    // DONE must line up with the write of the final index
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (state_q == DONE) |-> wr_valid_i && wr_last_i);

    // No result write ever appears while the engine is idle
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (state_q == IDLE) |-> !wr_valid_i);

endmodule

// ==== src/coef_counter.sv ====
`timescale 1ns/1ps

module coef_counter #(
    parameter int  NUM_COEFFS = 256,
    localparam int ADDR_W     = (NUM_COEFFS > 1) ? $clog2(NUM_COEFFS) : 1
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              clear_i,
    input  logic              advance_i,
    output logic [ADDR_W-1:0] count_o,
    output logic              last_o
);

    // Index of the final coefficient in a block
    localparam logic [ADDR_W-1:0] LAST_IDX = ADDR_W'(NUM_COEFFS - 1);

    logic [ADDR_W-1:0] count_q;
    logic [ADDR_W-1:0] count_next;

    // --------------------------------------------------
    // Index update
    // --------------------------------------------------

    // Wrap back to zero after the final index so a block never runs past its end
    assign count_next = (count_q == LAST_IDX) ? '0 : count_q + 1'b1;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (advance_i) begin
            count_q <= count_next;
        end
    end

    // The count is the address seen by the memory port
    assign count_o = count_q;

    // Flag stays high for the whole cycle the final index is presented
    assign last_o = (count_q == LAST_IDX);

    // Start only clears the counters while nothing moves through the datapath
    assert property (@(posedge clk) disable iff (!reset_n)
        !(clear_i && advance_i));

endmodule

// ==== src/decompose_center.sv ====
`timescale 1ns/1ps

module decompose_center #(
    parameter int DILITHIUM_Q = 8380417,
    parameter int GAMMA2      = (DILITHIUM_Q - 1) / 32
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  logic                 coef_valid_i,
    input  decompose_pkg::coef_t coef_i,
    input  logic                 rem_valid_i,
    input  decompose_pkg::rem_t  rem_i,
    output decompose_pkg::high_t r1_o,
    output decompose_pkg::coef_t r0_o,
    output logic                 valid_o
);
    import decompose_pkg::*;

    localparam int TWO_GAMMA2 = 2 * GAMMA2;
    // Multiples of 2*GAMMA2 up to q-1, the last one is the wrap case
    localparam int NUM_MULT   = (DILITHIUM_Q - 1) / TWO_GAMMA2;
    localparam int MULT_W     = $clog2(NUM_MULT + 1);
    // Two extra bits hold the sign of r0 and the headroom of r - r0
    localparam int WIDE_W     = COEF_W + 2;

    coef_t                    coef_q;
    logic                     r0_neg;
    logic signed [WIDE_W-1:0] r0_s;
    logic [WIDE_W-1:0]        r_minus_r0;
    logic [MULT_W-1:0]        mult_cnt;
    logic                     corner;
    high_t                    r1_next;
    coef_t                    r0_next;

    // --------------------------------------------------
    // Center the remainder and count the multiples
    // --------------------------------------------------

    always_comb begin
        // Remainders above GAMMA2 move to the negative side
        r0_neg = (rem_i > rem_t'(GAMMA2));
        r0_s   = signed'(WIDE_W'(rem_i));
        if (r0_neg) begin
            r0_s = r0_s - WIDE_W'(TWO_GAMMA2);
        end

        // r - r0 is an exact multiple of 2*GAMMA2
        r_minus_r0 = WIDE_W'(coef_q) - r0_s;

        // Compare chain against every multiple gives the quotient directly
        mult_cnt = '0;
        for (int j = 1; j <= NUM_MULT; j++) begin
            if (r_minus_r0 >= WIDE_W'(j * TWO_GAMMA2)) begin
                mult_cnt = mult_cnt + 1'b1;
            end
        end

        // At q-1 the high part wraps to zero and r0 steps down by one
        corner  = (r_minus_r0 == WIDE_W'(DILITHIUM_Q - 1));
        r1_next = corner ? '0 : high_t'(mult_cnt);
        if (corner) begin
            r0_s = r0_s - 1;
        end

        // Negative r0 is reported as q + r0
        r0_next = (r0_s < 0) ? coef_t'(r0_s + DILITHIUM_Q) : coef_t'(r0_s);
    end

    // Coefficient waits one cycle for its remainder, results are registered
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            coef_q <= '0;
            r1_o   <= '0;
            r0_o   <= '0;
        end else begin
            if (coef_valid_i) begin
                coef_q <= coef_i;
            end
            if (rem_valid_i) begin
                r1_o <= r1_next;
                r0_o <= r0_next;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else if (zeroize_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= rem_valid_i;
        end
    end

    // The held coefficient belongs to the read that produced this remainder
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        rem_valid_i |-> $past(coef_valid_i));

    // Outside the wrap case the multiple count fits the high part without losing a bit
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        rem_valid_i |-> (corner || (int'(mult_cnt) < (2 ** HIGH_W))));

endmodule

// ==== src/decompose_mod_2gamma2.sv ====
`timescale 1ns/1ps

module decompose_mod_2gamma2 #(
    parameter int DILITHIUM_Q = 8380417,
    parameter int GAMMA2      = (DILITHIUM_Q - 1) / 32
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  logic                 add_en_i,
    input  decompose_pkg::coef_t opa_i,
    output decompose_pkg::rem_t  res_o,
    output logic                 ready_o
);
    import decompose_pkg::*;

    // Number of coefficient bits above the remainder width
    localparam int HI_W       = COEF_W - REM_W;
    localparam int TWO_GAMMA2 = 2 * GAMMA2;
    // 2^REM_W overshoots 2*GAMMA2 by this much, so each unit of the top bits folds to it
    localparam int FOLD       = (2 ** REM_W) - TWO_GAMMA2;
    // Complement of 2*GAMMA2, together with a carry-in of one this subtracts 2*GAMMA2
    localparam rem_t NEG_2GAMMA2 = ~rem_t'(TWO_GAMMA2);

    logic [HI_W-1:0] opa_hi;
    rem_t            opa_lo;
    rem_t            fold_term;
    logic [REM_W:0]  sum0;
    logic [REM_W:0]  sum1;
    rem_t            sum0_q;
    logic            carry0_q;

    // --------------------------------------------------
    // Stage one folds the top bits into the low bits
    // --------------------------------------------------

    assign opa_hi    = opa_i[COEF_W-1:REM_W];
    assign opa_lo    = opa_i[REM_W-1:0];
    assign fold_term = rem_t'(opa_hi * FOLD);

    // The folded sum stays below two times 2*GAMMA2, so one conditional subtract finishes it
    assign sum0 = {1'b0, opa_lo} + {1'b0, fold_term};

    // Payload of the first stage, cleared by zeroize and loaded on each accepted coefficient
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            sum0_q   <= '0;
            carry0_q <= 1'b0;
        end else if (add_en_i) begin
            sum0_q   <= sum0[REM_W-1:0];
            carry0_q <= sum0[REM_W];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_o <= 1'b0;
        end else if (zeroize_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= add_en_i;
        end
    end

    // --------------------------------------------------
    // Stage two is a carry-select subtract of 2*GAMMA2
    // --------------------------------------------------

    assign sum1 = {1'b0, sum0_q} + {1'b0, NEG_2GAMMA2} + {{REM_W{1'b0}}, 1'b1};

    // The two carries differ exactly when the folded sum is at least 2*GAMMA2
    assign res_o = (carry0_q ^ sum1[REM_W]) ? sum1[REM_W-1:0] : sum0_q;

    // Every remainder leaving the reducer lies below 2*GAMMA2
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        ready_o |-> (res_o < rem_t'(TWO_GAMMA2)));

endmodule

// ==== src/decompose_pkg.sv ====
package decompose_pkg;

    // --------------------------------------------------
    // Fixed widths of the decompose datapath
    // --------------------------------------------------

    // A coefficient is always reduced below q, which fits in 23 bits
    localparam int COEF_W = 23;

    // Remainders modulo 2*GAMMA2 fit in 19 bits since 2*GAMMA2 is just below 2^19
    localparam int REM_W = 19;

    // The high part r1 ranges over 0 to 15 after the q-1 wrap
    localparam int HIGH_W = 4;

    // --------------------------------------------------
    // Datapath types
    // --------------------------------------------------

    // Input coefficient, also used for r0 once it is brought back to mod-q form
    typedef logic [COEF_W-1:0] coef_t;

    // Output of the modulo 2*GAMMA2 reducer
    typedef logic [REM_W-1:0] rem_t;

    // High part of the decomposition
    typedef logic [HIGH_W-1:0] high_t;

    // --------------------------------------------------
    // Controller states
    // --------------------------------------------------

    // IDLE waits for start, READ streams the block out of memory
    // FLUSH drains the pipeline, DONE carries the last write
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        FLUSH = 2'd2,
        DONE  = 2'd3
    } ctrl_state_e;

endpackage
